// File: rtl/pong_pkg.sv
package pong_pkg;

    typedef logic [7:0] coord_x_t;  // 0 to 159
    typedef logic [6:0] coord_y_t;  // 0 to 119
    typedef logic [2:0] colour_t;   // Red, green, blue

    // Diagonal heading of the ball
    typedef enum logic [1:0] {
        dir_up_right,
        dir_down_right,
        dir_down_left,
        dir_up_left
    } ball_dir_t;

    typedef enum logic [3:0] {
        s_init,
        s_background,
        s_ball,
        s_paddle,
        s_wait,
        s_move_paddle,
        s_check_touch,
        s_bounce,
        s_move_ball
    } frame_state_t;

    localparam coord_x_t screen_width  = 8'd160;
    localparam coord_y_t screen_height = 7'd120;

    localparam coord_x_t    paddle_width = 8'd18;
    localparam int unsigned paddle_rows  = 2;
    localparam int unsigned ball_pixels  = 12;   // Rounded 4x4 sprite

    localparam coord_x_t ball_start_x   = 8'd78;
    localparam coord_y_t ball_start_y   = 7'd58;
    localparam coord_x_t paddle_start_x = 8'd71;

    // Touch limits for the ball origin, which is the sprite's top left corner
    localparam logic [7:0] edge_low       = 8'd1;
    localparam coord_x_t   right_touch_x  = 8'd155;
    localparam coord_y_t   bottom_touch_y = 7'd113;

    localparam colour_t colour_black  = 3'b000;
    localparam colour_t colour_green  = 3'b010;
    localparam colour_t colour_red    = 3'b100;
    localparam colour_t colour_white  = 3'b111;
    localparam colour_t colour_paddle = 3'b011;

endpackage

// File: rtl/pixel_if.sv
`timescale 1ns/1ps

// One pixel write per cycle while plot is high
interface pixel_if;

    logic               plot;
    pong_pkg::coord_x_t x;
    pong_pkg::coord_y_t y;
    pong_pkg::colour_t  colour;

    modport painter (
        output plot, x, y, colour
    );

    modport sequencer (
        input plot, x, y, colour
    );

endinterface

// File: rtl/background_painter.sv
`timescale 1ns/1ps

module background_painter (
    input  logic      clk,
    input  logic      resetn,
    input  logic      start,
    output logic      done,
    pixel_if.painter  pix
);

    logic               active;
    pong_pkg::coord_x_t x_cnt;
    pong_pkg::coord_y_t y_cnt;
    logic               last_col;
    logic               last_row;

    assign last_col = (x_cnt == pong_pkg::screen_width - 8'd1);
    assign last_row = (y_cnt == pong_pkg::screen_height - 7'd1);

    // Raster scan with x running fastest
    always_ff @(posedge clk) begin
        if (!resetn) begin
            active <= 1'b0;
            x_cnt  <= '0;
            y_cnt  <= '0;
        end else if (start) begin
            active <= 1'b1;
            x_cnt  <= '0;
            y_cnt  <= '0;
        end else if (active) begin
            if (last_col) begin
                x_cnt <= '0;
                y_cnt <= y_cnt + 7'd1;
                if (last_row)
                    active <= 1'b0;
            end else begin
                x_cnt <= x_cnt + 8'd1;
            end
        end
    end

    assign done     = active && last_col && last_row;
    assign pix.plot = active;
    assign pix.x    = x_cnt;
    assign pix.y    = y_cnt;

    always_comb begin
        if (last_row)
            pix.colour = pong_pkg::colour_red;      // Floor below the paddle
        else if (x_cnt == '0 || last_col || y_cnt == '0)
            pix.colour = pong_pkg::colour_green;
        else
            pix.colour = pong_pkg::colour_black;
    end

endmodule

// File: rtl/ball_painter.sv
`timescale 1ns/1ps

module ball_painter (
    input  logic               clk,
    input  logic               resetn,
    input  logic               start,
    input  pong_pkg::coord_x_t ball_x,
    input  pong_pkg::coord_y_t ball_y,
    output logic               done,
    pixel_if.painter           pix
);

    logic       active;
    logic [3:0] idx;        // Sprite pixel index
    logic [1:0] dx;
    logic [1:0] dy;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            active <= 1'b0;
            idx    <= '0;
        end else if (start) begin
            active <= 1'b1;
            idx    <= '0;
        end else if (active) begin
            idx <= idx + 4'd1;
            if (done)
                active <= 1'b0;
        end
    end

    // Rounded 4x4 sprite without its corners
    always_comb begin
        case (idx)
            4'd0:    begin dx = 2'd1; dy = 2'd0; end
            4'd1:    begin dx = 2'd2; dy = 2'd0; end
            4'd2:    begin dx = 2'd0; dy = 2'd1; end
            4'd3:    begin dx = 2'd1; dy = 2'd1; end
            4'd4:    begin dx = 2'd2; dy = 2'd1; end
            4'd5:    begin dx = 2'd3; dy = 2'd1; end
            4'd6:    begin dx = 2'd0; dy = 2'd2; end
            4'd7:    begin dx = 2'd1; dy = 2'd2; end
            4'd8:    begin dx = 2'd2; dy = 2'd2; end
            4'd9:    begin dx = 2'd3; dy = 2'd2; end
            4'd10:   begin dx = 2'd1; dy = 2'd3; end
            default: begin dx = 2'd2; dy = 2'd3; end
        endcase
    end

    assign done       = active && (idx == 4'(pong_pkg::ball_pixels - 1));
    assign pix.plot   = active;
    assign pix.x      = ball_x + {6'd0, dx};
    assign pix.y      = ball_y + {5'd0, dy};
    assign pix.colour = pong_pkg::colour_white;

endmodule

// File: rtl/paddle_painter.sv
`timescale 1ns/1ps

module paddle_painter (
    input  logic               clk,
    input  logic               resetn,
    input  logic               start,
    input  pong_pkg::coord_x_t paddle_x,
    output logic               done,
    pixel_if.painter           pix
);

    logic       active;
    logic [4:0] col;
    logic       row;        // 0 is the lower row
    logic       last_col;

    assign last_col = (col == 5'(pong_pkg::paddle_width - 8'd1));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            active <= 1'b0;
            col    <= '0;
            row    <= 1'b0;
        end else if (start) begin
            active <= 1'b1;
            col    <= '0;
            row    <= 1'b0;
        end else if (active) begin
            col <= last_col ? 5'd0 : col + 5'd1;
            if (last_col)
                row <= !row;
            if (done)
                active <= 1'b0;
        end
    end

    assign done       = active && last_col && (row == 1'(pong_pkg::paddle_rows - 1));
    assign pix.plot   = active;
    assign pix.x      = paddle_x + {3'd0, col};
    assign pix.y      = pong_pkg::screen_height - 7'(pong_pkg::paddle_rows) - {6'd0, row};
    assign pix.colour = pong_pkg::colour_paddle;

endmodule

// File: rtl/object_motion.sv
`timescale 1ns/1ps

module object_motion (
    input  logic               clk,
    input  logic               resetn,
    input  logic               reset_objects,
    input  logic               move_paddle,
    input  logic               check_touch,
    input  logic               bounce,
    input  logic               move_ball,
    input  logic               left_key,
    input  logic               right_key,
    output logic               ball_touch,
    output pong_pkg::coord_x_t ball_x,
    output pong_pkg::coord_y_t ball_y,
    output pong_pkg::coord_x_t paddle_x
);

    pong_pkg::ball_dir_t ball_dir;
    logic                at_left;
    logic                at_top;
    logic                at_right;
    logic                at_bottom;
    logic                going_left;
    logic                going_down;
    logic                new_left;
    logic                new_down;
    logic                on_paddle;
    logic [8:0]          bx_ext;
    logic [8:0]          px_ext;

    assign at_left    = (ball_x <= pong_pkg::edge_low);
    assign at_top     = ({1'b0, ball_y} <= pong_pkg::edge_low);
    assign at_right   = (ball_x >= pong_pkg::right_touch_x);
    assign at_bottom  = (ball_y >= pong_pkg::bottom_touch_y);
    assign going_left = (ball_dir == pong_pkg::dir_down_left) ||
                        (ball_dir == pong_pkg::dir_up_left);
    assign going_down = (ball_dir == pong_pkg::dir_down_right) ||
                        (ball_dir == pong_pkg::dir_down_left);

    // 9 bits so the window below paddle_x does not wrap
    assign bx_ext = {1'b0, ball_x};
    assign px_ext = {1'b0, paddle_x};

    always_comb begin
        on_paddle = 1'b0;
        if (ball_y == pong_pkg::bottom_touch_y) begin
            if (ball_dir == pong_pkg::dir_down_right)
                on_paddle = (bx_ext + 9'd4 >= px_ext) && (bx_ext <= px_ext + 9'd16);
            else if (ball_dir == pong_pkg::dir_down_left)
                on_paddle = (bx_ext + 9'd2 >= px_ext) && (bx_ext <= px_ext + 9'd18);
        end
    end

    // Walls push the heading away, otherwise keep that component
    assign new_left = at_left ? 1'b0 : (at_right ? 1'b1 : going_left);
    assign new_down = at_top ? 1'b1 : (at_bottom ? 1'b0 : going_down);

    always_ff @(posedge clk) begin
        if (!resetn || reset_objects) begin
            ball_x   <= pong_pkg::ball_start_x;
            ball_y   <= pong_pkg::ball_start_y;
            ball_dir <= pong_pkg::dir_up_right;
        end else if (bounce) begin
            case ({new_down, new_left})
                2'b00:   ball_dir <= pong_pkg::dir_up_right;
                2'b10:   ball_dir <= pong_pkg::dir_down_right;
                2'b11:   ball_dir <= pong_pkg::dir_down_left;
                default: ball_dir <= pong_pkg::dir_up_left;
            endcase
        end else if (move_ball) begin
            ball_x <= going_left ? ball_x - 8'd1 : ball_x + 8'd1;
            ball_y <= going_down ? ball_y + 7'd1 : ball_y - 7'd1;  // Wraps after a miss
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ball_touch <= 1'b0;
        end else if (check_touch) begin
            ball_touch <= at_left || at_top || at_right || on_paddle;
        end
    end

    // Left key wins when both are held
    always_ff @(posedge clk) begin
        if (!resetn || reset_objects) begin
            paddle_x <= pong_pkg::paddle_start_x;
        end else if (move_paddle) begin
            if (left_key && paddle_x > pong_pkg::edge_low)
                paddle_x <= paddle_x - 8'd1;
            else if (right_key &&
                     paddle_x <= pong_pkg::screen_width - pong_pkg::paddle_width - 8'd1)
                paddle_x <= paddle_x + 8'd1;
        end
    end

endmodule

// File: rtl/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer #(
    parameter int unsigned frame_wait = 1562500
) (
    input  logic               clk,
    input  logic               resetn,
    pixel_if.sequencer         bg_pix,
    pixel_if.sequencer         ball_pix,
    pixel_if.sequencer         paddle_pix,
    input  logic               bg_done,
    input  logic               ball_done,
    input  logic               paddle_done,
    input  logic               ball_touch,
    output logic               bg_start,
    output logic               ball_start,
    output logic               paddle_start,
    output logic               move_paddle,
    output logic               check_touch,
    output logic               bounce,
    output logic               move_ball,
    output logic               reset_objects,
    output logic               plot,
    output pong_pkg::coord_x_t x,
    output pong_pkg::coord_y_t y,
    output pong_pkg::colour_t  colour
);

    pong_pkg::frame_state_t state;
    pong_pkg::frame_state_t next_state;
    logic                   state_first;    // High in the first cycle of a state
    logic                   frame_odd;
    logic [31:0]            wait_count;

    always_comb begin
        next_state = state;
        case (state)
            pong_pkg::s_init:       next_state = pong_pkg::s_background;
            pong_pkg::s_background: if (bg_done) next_state = pong_pkg::s_ball;
            pong_pkg::s_ball:       if (ball_done) next_state = pong_pkg::s_paddle;
            pong_pkg::s_paddle:     if (paddle_done) next_state = pong_pkg::s_wait;
            pong_pkg::s_wait: begin
                if (wait_count == frame_wait - 32'd1)
                    next_state = pong_pkg::s_move_paddle;
            end
            pong_pkg::s_move_paddle: begin
                // Ball only moves on every second frame
                next_state = frame_odd ? pong_pkg::s_check_touch : pong_pkg::s_background;
            end
            pong_pkg::s_check_touch: begin
                // Touch result is ready one cycle after the check
                if (!state_first)
                    next_state = ball_touch ? pong_pkg::s_bounce : pong_pkg::s_move_ball;
            end
            pong_pkg::s_bounce:     next_state = pong_pkg::s_move_ball;
            pong_pkg::s_move_ball:  next_state = pong_pkg::s_background;
            default:                next_state = pong_pkg::s_init;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= pong_pkg::s_init;
            state_first <= 1'b1;
            frame_odd   <= 1'b0;
            wait_count  <= '0;
        end else begin
            state       <= next_state;
            state_first <= (next_state != state);
            if (state == pong_pkg::s_move_paddle)
                frame_odd <= !frame_odd;
            if (state == pong_pkg::s_wait)
                wait_count <= wait_count + 32'd1;
            else
                wait_count <= '0;
        end
    end

    // Painter starts fall in the first cycle of their state, so plot idles one cycle
    assign bg_start      = (state == pong_pkg::s_background) && state_first;
    assign ball_start    = (state == pong_pkg::s_ball) && state_first;
    assign paddle_start  = (state == pong_pkg::s_paddle) && state_first;
    assign move_paddle   = (state == pong_pkg::s_move_paddle);
    assign check_touch   = (state == pong_pkg::s_check_touch) && state_first;
    assign bounce        = (state == pong_pkg::s_bounce);
    assign move_ball     = (state == pong_pkg::s_move_ball);
    assign reset_objects = (state == pong_pkg::s_init);

    // Pixel port goes to the painter of the current state
    always_comb begin
        plot   = 1'b0;
        x      = '0;
        y      = '0;
        colour = pong_pkg::colour_black;
        case (state)
            pong_pkg::s_background: begin
                plot   = bg_pix.plot;
                x      = bg_pix.x;
                y      = bg_pix.y;
                colour = bg_pix.colour;
            end
            pong_pkg::s_ball: begin
                plot   = ball_pix.plot;
                x      = ball_pix.x;
                y      = ball_pix.y;
                colour = ball_pix.colour;
            end
            pong_pkg::s_paddle: begin
                plot   = paddle_pix.plot;
                x      = paddle_pix.x;
                y      = paddle_pix.y;
                colour = paddle_pix.colour;
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/bouncy_ball_top.sv
`timescale 1ns/1ps

module bouncy_ball_top #(
    parameter int unsigned frame_wait = 1562500
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               left_key,
    input  logic               right_key,
    output logic               plot,
    output pong_pkg::coord_x_t x,
    output pong_pkg::coord_y_t y,
    output pong_pkg::colour_t  colour
);

    logic               bg_start;
    logic               ball_start;
    logic               paddle_start;
    logic               bg_done;
    logic               ball_done;
    logic               paddle_done;
    logic               move_paddle;
    logic               check_touch;
    logic               bounce;
    logic               move_ball;
    logic               reset_objects;
    logic               ball_touch;
    pong_pkg::coord_x_t ball_x;
    pong_pkg::coord_y_t ball_y;
    pong_pkg::coord_x_t paddle_x;

    pixel_if bg_pix ();
    pixel_if ball_pix ();
    pixel_if paddle_pix ();

    frame_sequencer #(
        .frame_wait (frame_wait)
    ) seq0 (
        .clk           (clk),
        .resetn        (resetn),
        .bg_pix        (bg_pix.sequencer),
        .ball_pix      (ball_pix.sequencer),
        .paddle_pix    (paddle_pix.sequencer),
        .bg_done       (bg_done),
        .ball_done     (ball_done),
        .paddle_done   (paddle_done),
        .ball_touch    (ball_touch),
        .bg_start      (bg_start),
        .ball_start    (ball_start),
        .paddle_start  (paddle_start),
        .move_paddle   (move_paddle),
        .check_touch   (check_touch),
        .bounce        (bounce),
        .move_ball     (move_ball),
        .reset_objects (reset_objects),
        .plot          (plot),
        .x             (x),
        .y             (y),
        .colour        (colour)
    );

    background_painter bg0 (
        .clk    (clk),
        .resetn (resetn),
        .start  (bg_start),
        .done   (bg_done),
        .pix    (bg_pix.painter)
    );

    ball_painter ball0 (
        .clk    (clk),
        .resetn (resetn),
        .start  (ball_start),
        .ball_x (ball_x),
        .ball_y (ball_y),
        .done   (ball_done),
        .pix    (ball_pix.painter)
    );

    paddle_painter paddle0 (
        .clk      (clk),
        .resetn   (resetn),
        .start    (paddle_start),
        .paddle_x (paddle_x),
        .done     (paddle_done),
        .pix      (paddle_pix.painter)
    );

    object_motion motion0 (
        .clk           (clk),
        .resetn        (resetn),
        .reset_objects (reset_objects),
        .move_paddle   (move_paddle),
        .check_touch   (check_touch),
        .bounce        (bounce),
        .move_ball     (move_ball),
        .left_key      (left_key),
        .right_key     (right_key),
        .ball_touch    (ball_touch),
        .ball_x        (ball_x),
        .ball_y        (ball_y),
        .paddle_x      (paddle_x)
    );

endmodule

// File: sim/bouncy_ball_properties.sv
`timescale 1ns/1ps

module bouncy_ball_properties (
    input logic               clk,
    input logic               resetn,
    input logic               plot,
    input pong_pkg::coord_x_t x,
    input pong_pkg::coord_y_t y,
    input pong_pkg::colour_t  colour
);

    int unsigned        error_count = 0;
    int                 plot_idx;       // 0 to 19247 within a frame
    logic               first_frame;
    pong_pkg::coord_x_t ball_ox;
    pong_pkg::coord_y_t ball_oy;
    pong_pkg::coord_x_t prev_x;

    function automatic pong_pkg::colour_t bg_colour(input int col, input int row);
        if (row == 119)
            return pong_pkg::colour_red;
        if (col == 0 || col == 159 || row == 0)
            return pong_pkg::colour_green;
        return pong_pkg::colour_black;
    endfunction

    // Sprite rows hold 2, 4, 4 and 2 pixels; the short rows start at 1
    function automatic int ball_dx(input int k);
        if (k < 2)
            return k + 1;
        if (k < 6)
            return k - 2;
        if (k < 10)
            return k - 6;
        return k - 9;
    endfunction

    function automatic int ball_dy(input int k);
        if (k < 2)
            return 0;
        if (k < 6)
            return 1;
        if (k < 10)
            return 2;
        return 3;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            plot_idx    <= 0;
            first_frame <= 1'b1;
        end else if (plot) begin
            prev_x <= x;
            if (plot_idx == 19200) begin
                ball_ox <= x - 8'd1;        // First sprite pixel sits at (1,0)
                ball_oy <= y;
            end
            if (plot_idx == 19247) begin
                plot_idx    <= 0;
                first_frame <= 1'b0;
            end else begin
                plot_idx <= plot_idx + 1;
            end
        end
    end

    reset_plot_low: assert property (@(posedge clk) !resetn |=> !plot ##1 !plot)
        else begin
            error_count++;
            $error("ERROR reset_plot_low: expected plot 0, actual plot %0d", $sampled(plot));
        end

    plot_in_screen: assert property (@(posedge clk) disable iff (!resetn)
        plot && (plot_idx < 19200 || plot_idx >= 19212) |->
            x < pong_pkg::screen_width && y < pong_pkg::screen_height)
        else begin
            error_count++;
            $error("ERROR plot_in_screen: expected x < 160 and y < 120, actual (%0d,%0d)",
                   $sampled(x), $sampled(y));
        end

    background_raster: assert property (@(posedge clk) disable iff (!resetn)
        plot && plot_idx < 19200 |->
            int'(x) == plot_idx % 160 && int'(y) == plot_idx / 160 &&
            colour == bg_colour(plot_idx % 160, plot_idx / 160))
        else begin
            error_count++;
            $error("ERROR background_raster: expected (%0d,%0d,%0d), actual (%0d,%0d,%0d)",
                   $sampled(plot_idx) % 160, $sampled(plot_idx) / 160,
                   bg_colour($sampled(plot_idx) % 160, $sampled(plot_idx) / 160),
                   $sampled(x), $sampled(y), $sampled(colour));
        end

    ball_colour: assert property (@(posedge clk) disable iff (!resetn)
        plot && plot_idx >= 19200 && plot_idx < 19212 |-> colour == pong_pkg::colour_white)
        else begin
            error_count++;
            $error("ERROR ball_colour: expected colour %0d, actual colour %0d",
                   pong_pkg::colour_white, $sampled(colour));
        end

    ball_shape: assert property (@(posedge clk) disable iff (!resetn)
        plot && plot_idx > 19200 && plot_idx < 19212 |->
            x == ball_ox + 8'(ball_dx(plot_idx - 19200)) &&
            y == ball_oy + 7'(ball_dy(plot_idx - 19200)))
        else begin
            error_count++;
            $error("ERROR ball_shape: expected (%0d,%0d), actual (%0d,%0d)",
                   $sampled(ball_ox) + ball_dx($sampled(plot_idx) - 19200),
                   $sampled(ball_oy) + ball_dy($sampled(plot_idx) - 19200),
                   $sampled(x), $sampled(y));
        end

    ball_start: assert property (@(posedge clk) disable iff (!resetn)
        plot && plot_idx == 19200 && first_frame |->
            x == pong_pkg::ball_start_x + 8'd1 && y == pong_pkg::ball_start_y)
        else begin
            error_count++;
            $error("ERROR ball_start: expected (%0d,%0d), actual (%0d,%0d)",
                   pong_pkg::ball_start_x + 8'd1, pong_pkg::ball_start_y,
                   $sampled(x), $sampled(y));
        end

    paddle_row: assert property (@(posedge clk) disable iff (!resetn)
        plot && plot_idx >= 19212 |->
            colour == pong_pkg::colour_paddle && y == (plot_idx < 19230 ? 7'd118 : 7'd117))
        else begin
            error_count++;
            $error("ERROR paddle_row: expected y %0d colour %0d, actual y %0d colour %0d",
                   ($sampled(plot_idx) < 19230) ? 118 : 117, pong_pkg::colour_paddle,
                   $sampled(y), $sampled(colour));
        end

    paddle_run: assert property (@(posedge clk) disable iff (!resetn)
        plot && plot_idx >= 19212 && (plot_idx - 19212) % 18 != 0 |-> x == prev_x + 8'd1)
        else begin
            error_count++;
            $error("ERROR paddle_run: expected x %0d, actual x %0d",
                   $sampled(prev_x) + 8'd1, $sampled(x));
        end

endmodule

// File: sim/bouncy_ball_tb.sv
`timescale 1ns/1ps

module bouncy_ball_tb;

    logic               clk;
    logic               resetn;
    logic               left_key;
    logic               right_key;
    logic               plot;
    pong_pkg::coord_x_t x;
    pong_pkg::coord_y_t y;
    pong_pkg::colour_t  colour;

    int   plot_count;
    int   frame_count;
    int   cur_ox;
    int   cur_oy;
    int   cur_px;
    int   ox_q[$];      // Ball origin per frame
    int   oy_q[$];
    int   paddle_q[$];
    logic right_q[$];   // Keys held at the end of each frame
    logic left_q[$];
    bit   timed_out;
    int   tests_passed;
    int   tests_failed;

    bouncy_ball_top #(
        .frame_wait (16)
    ) dut0 (
        .clk       (clk),
        .resetn    (resetn),
        .left_key  (left_key),
        .right_key (right_key),
        .plot      (plot),
        .x         (x),
        .y         (y),
        .colour    (colour)
    );

    bind bouncy_ball_top bouncy_ball_properties props0 (
        .clk    (clk),
        .resetn (resetn),
        .plot   (plot),
        .x      (x),
        .y      (y),
        .colour (colour)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Frame tracking over 19200 background, 12 ball and 36 paddle plots
    always @(posedge clk) begin
        if (!resetn) begin
            plot_count  <= 0;
            frame_count <= 0;
        end else if (plot) begin
            if (plot_count == 19200) begin
                cur_ox <= int'(x) - 1;
                cur_oy <= int'(y);
            end
            if (plot_count == 19212)
                cur_px <= int'(x);
            if (plot_count == 19247) begin
                ox_q.push_back(cur_ox);
                oy_q.push_back(cur_oy);
                paddle_q.push_back(cur_px);
                right_q.push_back(right_key);
                left_q.push_back(left_key);
                plot_count  <= 0;
                frame_count <= frame_count + 1;
            end else begin
                plot_count <= plot_count + 1;
            end
        end
    end

    task automatic wait_frames(input int target);
        int seen;
        int cycles;
        while (frame_count < target && !timed_out) begin
            seen   = frame_count;
            cycles = 0;
            while (frame_count == seen && cycles < 3000000) begin
                @(posedge clk);
                #1;
                cycles++;
            end
            if (frame_count == seen) begin
                $display("timeout: no frame boundary within 3000000 cycles after frame %0d", seen);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic report_mismatch(input string test, input int frame,
                                   input string expected, input string actual);
        $display("ERROR %s frame %0d: expected %s, actual %s", test, frame, expected, actual);
    endtask

    task automatic log_test_result(input string test, input int errors);
        if (errors == 0) begin
            $display("test %s: pass", test);
            tests_passed++;
        end else begin
            $display("test %s: fail with %0d errors", test, errors);
            tests_failed++;
        end
    endtask

    // Left key wins and the paddle stays within 1 to 142
    task automatic check_paddle_motion(output int errors);
        int expected;
        bit right_end;
        errors    = 0;
        right_end = 1'b0;
        assert (paddle_q[0] == 71) else begin
            report_mismatch("paddle_motion", 0, "71", $sformatf("%0d", paddle_q[0]));
            errors++;
        end
        for (int f = 1; f < paddle_q.size(); f++) begin
            expected = paddle_q[f - 1];
            if (left_q[f] && expected > 1)
                expected--;
            else if (right_q[f] && expected <= 141)
                expected++;
            assert (paddle_q[f] == expected) else begin
                report_mismatch("paddle_motion", f, $sformatf("%0d", expected),
                                $sformatf("%0d", paddle_q[f]));
                errors++;
            end
            if (paddle_q[f] == 142)
                right_end = 1'b1;
        end
        assert (right_end && paddle_q[paddle_q.size() - 1] == 1) else begin
            $display("paddle_motion: the paddle did not reach both ends of its range");
            errors++;
        end
    endtask

    task automatic check_ball_motion(output int errors);
        int dx;
        int dy;
        int top;
        int g;
        int last;
        errors = 0;
        top    = -1;
        last   = ox_q.size() - 1;
        for (int f = 0; f < last; f++) begin
            dx = ox_q[f + 1] - ox_q[f];
            dy = oy_q[f + 1] - oy_q[f];
            if (f % 2 == 0) begin
                assert (dx == 0 && dy == 0) else begin
                    report_mismatch("ball_motion", f + 1, "no step",
                                    $sformatf("step (%0d,%0d)", dx, dy));
                    errors++;
                end
            end else begin
                assert ((dx == 1 || dx == -1) && (dy == 1 || dy == -1)) else begin
                    report_mismatch("ball_motion", f + 1, "one diagonal step",
                                    $sformatf("step (%0d,%0d)", dx, dy));
                    errors++;
                end
            end
            if (top < 0 && oy_q[f] <= 1)
                top = f;
        end
        assert (ox_q[2] == 79 && oy_q[2] == 57) else begin
            report_mismatch("ball_motion", 2, "(79,57)",
                            $sformatf("(%0d,%0d)", ox_q[2], oy_q[2]));
            errors++;
        end
        if (top < 0) begin
            $display("ball_motion: the ball never reached the top wall");
            errors++;
        end else begin
            g = (top % 2 == 1) ? top : top + 1;     // Next frame that moves the ball
            if (g + 1 > last) begin
                $display("ball_motion: too few frames after the ball reached the top wall");
                errors++;
            end else begin
                assert (oy_q[g + 1] == oy_q[g] + 1) else begin
                    report_mismatch("ball_motion", g + 1, $sformatf("y %0d", oy_q[g] + 1),
                                    $sformatf("y %0d", oy_q[g + 1]));
                    errors++;
                end
            end
        end
    endtask

    initial begin : main
        int errors;
        resetn       = 1'b0;
        left_key     = 1'b0;
        right_key    = 1'b0;
        timed_out    = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (2) @(posedge clk);
        #1;
        resetn    = 1'b1;
        right_key = 1'b1;
        wait_frames(80);
        if (!timed_out) begin
            right_key = 1'b0;
            left_key  = 1'b1;
            wait_frames(241);
        end
        if (!timed_out) begin
            check_paddle_motion(errors);
            log_test_result("paddle_motion", errors);
            check_ball_motion(errors);
            log_test_result("ball_motion", errors);
        end
        log_test_result("frame_assertions", int'(dut0.props0.error_count));
        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && !timed_out)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: sim.f
rtl/pong_pkg.sv
rtl/pixel_if.sv
rtl/background_painter.sv
rtl/ball_painter.sv
rtl/paddle_painter.sv
rtl/object_motion.sv
rtl/frame_sequencer.sv
rtl/bouncy_ball_top.sv
sim/bouncy_ball_properties.sv
sim/bouncy_ball_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= bouncy_ball_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
RUNFLAGS  ?= +verilator+error+limit+1000
PASS_TEXT  = ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
